// File: Bender.yml
package:
  name: cheri_cap_alu

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cheri_cap_pkg.sv
      - rtl/cap_operand_decode.sv
      - rtl/cap_check_stage.sv
      - rtl/cap_execute.sv
      - rtl/cheri_cap_alu.sv
  - target: test
    include_dirs:
      - rtl
    files:
      - test/tb_cheri_cap_alu.sv

// File: flist.f
+incdir+rtl
rtl/cheri_cap_pkg.sv
rtl/cap_operand_decode.sv
rtl/cap_check_stage.sv
rtl/cap_execute.sv
rtl/cheri_cap_alu.sv
test/tb_cheri_cap_alu.sv

// File: rtl/cap_check_stage.sv
`include "cheri_cap_settings.svh"
`timescale 1ns/1ps

// first pipeline stage
// all bounds, type and permission comparisons are made here and registered as flags,
// so the execute stage only has to mask them into the exception vectors
module cap_check_stage (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     in_valid_i,
  input  logic [`OP_W-1:0]         op_i,
  input  cheri_cap_pkg::cap_word_u operand_a_i,
  input  cheri_cap_pkg::cap_word_u operand_b_i,
  input  logic                     a_tag_i,
  input  logic                     a_sealed_i,
  input  logic [`PERMS_W-1:0]      a_perms_i,
  input  logic [`OTYPE_W-1:0]      a_otype_i,
  input  logic [`INT_W-1:0]        a_base_i,
  input  logic [`TOP_W-1:0]        a_top_i,
  input  logic [`INT_W-1:0]        a_addr_i,
  input  logic [`INT_W-1:0]        a_offset_i,
  input  logic                     b_tag_i,
  input  logic                     b_sealed_i,
  input  logic [`PERMS_W-1:0]      b_perms_i,
  input  logic [`INT_W-1:0]        b_base_i,
  input  logic [`TOP_W-1:0]        b_top_i,
  input  logic [`INT_W-1:0]        b_addr_i,
  output logic                     valid_o,
  output logic [`OP_W-1:0]         op_o,
  output cheri_cap_pkg::cap_word_u operand_a_o,
  output cheri_cap_pkg::cap_word_u operand_b_o,
  output logic [`INT_W-1:0]        a_offset_o,
  output logic                     a_tag_bad_o,
  output logic                     a_seal_bad_o,
  output logic                     a_sealed_o,
  output logic                     b_tag_bad_o,
  output logic                     b_seal_bad_o,
  output logic                     b_sealed_o,
  output logic                     b_no_seal_perm_o,
  output logic                     b_no_unseal_perm_o,
  output logic                     b_addr_out_of_bounds_o,
  output logic                     b_addr_over_max_otype_o,
  output logic                     a_bounds_bad_o,
  output logic                     type_mismatch_o,
  output logic                     subset_o
);
  import cheri_cap_pkg::*;

  // b read as a plain integer, used as the requested length by set-bounds
  cap_int_s          b_int;
  // top that set-bounds would produce, one bit wider so the sum cannot wrap
  logic [`TOP_W-1:0] a_new_top;

  assign b_int     = operand_b_i.num;
  assign a_new_top = {1'b0, a_addr_i} + {1'b0, b_int.value};

  // only the valid bit is cleared, the payload below loads on a valid input
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i) begin
      op_o        <= op_i;
      operand_a_o <= operand_a_i;
      operand_b_o <= operand_b_i;
      a_offset_o  <= a_offset_i;

      a_tag_bad_o <= !a_tag_i;
      b_tag_bad_o <= !b_tag_i;
      a_sealed_o  <= a_sealed_i;
      b_sealed_o  <= b_sealed_i;
      // a seal violation only counts on a tagged capability
      a_seal_bad_o <= a_tag_i && a_sealed_i;
      b_seal_bad_o <= b_tag_i && b_sealed_i;

      b_no_seal_perm_o   <= !b_perms_i[`PERMIT_SEAL_IDX];
      b_no_unseal_perm_o <= !b_perms_i[`PERMIT_UNSEAL_IDX];

      // b used as a sealing authority must point inside its own bounds
      b_addr_out_of_bounds_o  <= ({1'b0, b_addr_i} >= b_top_i);
      b_addr_over_max_otype_o <= (b_addr_i > `MAX_OTYPE);

      // new bounds must start inside a and must not reach past a's top
      a_bounds_bad_o <= (a_addr_i < a_base_i) || (a_new_top > a_top_i);

      type_mismatch_o <= (b_addr_i != {{(`INT_W-`OTYPE_W){1'b0}}, a_otype_i});

      // b is a subset of a when tags agree, bounds nest and no perm is added
      subset_o <= (a_tag_i == b_tag_i) &&
                  (b_base_i >= a_base_i) &&
                  (b_top_i <= a_top_i) &&
                  ((b_perms_i & a_perms_i) == b_perms_i);
    end
  end

endmodule

// File: rtl/cap_execute.sv
`include "cheri_cap_settings.svh"
`timescale 1ns/1ps

// second pipeline stage
// builds the result word from the registered operands and folds the precomputed flags
// into one exception vector per operand, then registers everything for the core
module cap_execute (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     valid_i,
  input  logic [`OP_W-1:0]         op_i,
  input  cheri_cap_pkg::cap_word_u operand_a_i,
  input  cheri_cap_pkg::cap_word_u operand_b_i,
  input  logic [`INT_W-1:0]        a_offset_i,
  input  logic                     a_tag_bad_i,
  input  logic                     a_seal_bad_i,
  input  logic                     a_sealed_i,
  input  logic                     b_tag_bad_i,
  input  logic                     b_seal_bad_i,
  input  logic                     b_sealed_i,
  input  logic                     b_no_seal_perm_i,
  input  logic                     b_no_unseal_perm_i,
  input  logic                     b_addr_out_of_bounds_i,
  input  logic                     b_addr_over_max_otype_i,
  input  logic                     a_bounds_bad_i,
  input  logic                     type_mismatch_i,
  input  logic                     subset_i,
  output logic                     valid_o,
  output cheri_cap_pkg::cap_word_u result_o,
  output logic                     wrote_cap_o,
  output logic [`EXC_W-1:0]        exc_a_o,
  output logic [`EXC_W-1:0]        exc_b_o
);
  import cheri_cap_pkg::*;

  cap_word_u         result_d;
  logic              wrote_cap_d;
  logic [`EXC_W-1:0] exc_a_d;
  logic [`EXC_W-1:0] exc_b_d;

  always_comb begin
    // integer results leave the upper field at zero and write no capability
    result_d    = '0;
    wrote_cap_d = 1'b0;
    exc_a_d     = '0;
    exc_b_d     = '0;

    case (op_i)
      `OP_GET_PERM: begin
        result_d.num.value = {{(`INT_W-`PERMS_W){1'b0}}, operand_a_i.cap.perms};
      end

      `OP_GET_TYPE: begin
        // an unsealed capability reports minus one rather than its reserved type
        if (a_sealed_i) begin
          result_d.num.value = {{(`INT_W-`OTYPE_W){1'b0}}, operand_a_i.cap.otype};
        end else begin
          result_d.num.value = '1;
        end
      end

      `OP_GET_BASE: begin
        result_d.num.value = operand_a_i.cap.base;
      end

      `OP_GET_LEN: begin
        result_d.num.value = operand_a_i.cap.length;
      end

      `OP_GET_TAG: begin
        result_d.num.value = {{(`INT_W-1){1'b0}}, operand_a_i.cap.tag};
      end

      `OP_GET_SEALED: begin
        result_d.num.value = {{(`INT_W-1){1'b0}}, a_sealed_i};
      end

      `OP_GET_OFFSET: begin
        result_d.num.value = a_offset_i;
      end

      `OP_GET_ADDR: begin
        result_d.num.value = operand_a_i.cap.addr;
      end

      `OP_MOVE: begin
        result_d    = operand_a_i;
        wrote_cap_d = 1'b1;
      end

      `OP_CLEAR_TAG: begin
        result_d         = operand_a_i;
        result_d.cap.tag = 1'b0;
        wrote_cap_d      = 1'b1;
      end

      `OP_AND_PERM: begin
        result_d           = operand_a_i;
        result_d.cap.perms = operand_a_i.cap.perms & operand_b_i.num.value[`PERMS_W-1:0];
        wrote_cap_d        = 1'b1;
        exc_a_d[`EXC_TAG]  = a_tag_bad_i;
        exc_a_d[`EXC_SEAL] = a_seal_bad_i;
      end

      `OP_SET_ADDR: begin
        result_d           = operand_a_i;
        result_d.cap.addr  = operand_b_i.num.value;
        wrote_cap_d        = 1'b1;
        exc_a_d[`EXC_SEAL] = a_seal_bad_i;
      end

      `OP_INC_OFFSET: begin
        // moving the address by b is the same as moving the offset by b
        result_d           = operand_a_i;
        result_d.cap.addr  = operand_a_i.cap.addr + operand_b_i.num.value;
        wrote_cap_d        = 1'b1;
        exc_a_d[`EXC_SEAL] = a_seal_bad_i;
      end

      `OP_SET_BOUNDS: begin
        // the new region starts at the current address and is b bytes long
        result_d             = operand_a_i;
        result_d.cap.base    = operand_a_i.cap.addr;
        result_d.cap.length  = operand_b_i.num.value;
        wrote_cap_d          = 1'b1;
        exc_a_d[`EXC_TAG]    = a_tag_bad_i;
        exc_a_d[`EXC_SEAL]   = a_seal_bad_i;
        exc_a_d[`EXC_LENGTH] = a_bounds_bad_i;
      end

      `OP_SEAL: begin
        // b is the sealing authority and its address selects the new type
        result_d                  = operand_a_i;
        result_d.cap.otype        = operand_b_i.cap.addr[`OTYPE_W-1:0];
        wrote_cap_d               = 1'b1;
        exc_a_d[`EXC_TAG]         = a_tag_bad_i;
        exc_a_d[`EXC_SEAL]        = a_seal_bad_i;
        exc_b_d[`EXC_TAG]         = b_tag_bad_i;
        exc_b_d[`EXC_SEAL]        = b_seal_bad_i;
        exc_b_d[`EXC_PERMIT_SEAL] = b_no_seal_perm_i;
        exc_b_d[`EXC_LENGTH]      = b_addr_out_of_bounds_i || b_addr_over_max_otype_i;
      end

      `OP_UNSEAL: begin
        // the result keeps global only if both a and the authority b are global
        result_d                                 = operand_a_i;
        result_d.cap.otype                       = `OTYPE_UNSEALED;
        result_d.cap.perms[`PERMIT_GLOBAL_IDX]   =
          operand_a_i.cap.perms[`PERMIT_GLOBAL_IDX] &
          operand_b_i.cap.perms[`PERMIT_GLOBAL_IDX];
        wrote_cap_d                 = 1'b1;
        exc_a_d[`EXC_TAG]           = a_tag_bad_i;
        exc_a_d[`EXC_SEAL]          = !a_sealed_i;
        exc_b_d[`EXC_TAG]           = b_tag_bad_i;
        exc_b_d[`EXC_SEAL]          = b_sealed_i;
        exc_b_d[`EXC_TYPE]          = type_mismatch_i;
        exc_b_d[`EXC_PERMIT_UNSEAL] = b_no_unseal_perm_i;
        exc_b_d[`EXC_LENGTH]        = b_addr_out_of_bounds_i;
      end

      `OP_SUB: begin
        result_d.num.value = operand_a_i.cap.addr - operand_b_i.cap.addr;
      end

      `OP_TEST_SUBSET: begin
        result_d.num.value = {{(`INT_W-1){1'b0}}, subset_i};
      end

      default: begin
        // unknown codes return a zero integer with no exceptions
      end
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      valid_o <= 1'b0;
    end else begin
      valid_o <= valid_i;
    end
  end

  // result and exception registers hold their last value between valid cycles
  always_ff @(posedge clk_i) begin
    if (valid_i) begin
      result_o    <= result_d;
      wrote_cap_o <= wrote_cap_d;
      exc_a_o     <= exc_a_d;
      exc_b_o     <= exc_b_d;
    end
  end

endmodule

// File: rtl/cap_operand_decode.sv
`include "cheri_cap_settings.svh"
`timescale 1ns/1ps

// splits one operand word into its capability fields and derives top, offset and sealed
// this is pure logic and sits in front of the check stage register
module cap_operand_decode (
  input  cheri_cap_pkg::cap_word_u cap_i,
  output logic                     tag_o,
  output logic                     sealed_o,
  output logic [`PERMS_W-1:0]      perms_o,
  output logic [`OTYPE_W-1:0]      otype_o,
  output logic [`INT_W-1:0]        base_o,
  output logic [`INT_W-1:0]        addr_o,
  output logic [`INT_W-1:0]        offset_o,
  output logic [`TOP_W-1:0]        top_o
);
  import cheri_cap_pkg::*;

  cap_fields_s fields;

  assign fields = cap_i.cap;

  assign tag_o   = fields.tag;
  assign perms_o = fields.perms;
  assign otype_o = fields.otype;
  assign base_o  = fields.base;
  assign addr_o  = fields.addr;

  // top carries one extra bit so a region that ends at the top of memory stays exact
  assign top_o = {1'b0, fields.base} + {1'b0, fields.length};

  // offset wraps like the address does, so no extra bit here
  assign offset_o = fields.addr - fields.base;

  // any type other than the reserved all-ones value means the capability is sealed
  assign sealed_o = (fields.otype != `OTYPE_UNSEALED);

endmodule

// File: rtl/cheri_cap_alu.sv
`include "cheri_cap_settings.svh"
`timescale 1ns/1ps

// capability ALU, two stages deep
// an in_valid_i pulse comes back as an out_valid_o pulse two cycles later,
// and a new operation may enter on every cycle
module cheri_cap_alu (
  input  logic                     clk_i,
  input  logic                     rst_n_i,
  input  logic                     in_valid_i,
  input  logic [`OP_W-1:0]         op_i,
  input  cheri_cap_pkg::cap_word_u operand_a_i,
  input  cheri_cap_pkg::cap_word_u operand_b_i,
  output logic                     out_valid_o,
  output cheri_cap_pkg::cap_word_u result_o,
  output logic                     wrote_cap_o,
  output logic [`EXC_W-1:0]        exc_a_o,
  output logic [`EXC_W-1:0]        exc_b_o
);
  import cheri_cap_pkg::*;

  // decoded fields of the raw operands
  logic                a_tag;
  logic                a_sealed;
  logic [`PERMS_W-1:0] a_perms;
  logic [`OTYPE_W-1:0] a_otype;
  logic [`INT_W-1:0]   a_base;
  logic [`INT_W-1:0]   a_addr;
  logic [`INT_W-1:0]   a_offset;
  logic [`TOP_W-1:0]   a_top;
  logic                b_tag;
  logic                b_sealed;
  logic [`PERMS_W-1:0] b_perms;
  logic [`INT_W-1:0]   b_base;
  logic [`INT_W-1:0]   b_addr;
  logic [`TOP_W-1:0]   b_top;

  // check stage register outputs feeding the execute stage
  logic              chk_valid;
  logic [`OP_W-1:0]  chk_op;
  cap_word_u         chk_operand_a;
  cap_word_u         chk_operand_b;
  logic [`INT_W-1:0] chk_a_offset;
  logic              a_tag_bad;
  logic              a_seal_bad;
  logic              chk_a_sealed;
  logic              b_tag_bad;
  logic              b_seal_bad;
  logic              chk_b_sealed;
  logic              b_no_seal_perm;
  logic              b_no_unseal_perm;
  logic              b_addr_out_of_bounds;
  logic              b_addr_over_max_otype;
  logic              a_bounds_bad;
  logic              type_mismatch;
  logic              subset;

  cap_operand_decode u_decode_a (
    .cap_i    (operand_a_i),
    .tag_o    (a_tag),
    .sealed_o (a_sealed),
    .perms_o  (a_perms),
    .otype_o  (a_otype),
    .base_o   (a_base),
    .addr_o   (a_addr),
    .offset_o (a_offset),
    .top_o    (a_top)
  );

  // b's type and offset are never needed
  cap_operand_decode u_decode_b (
    .cap_i    (operand_b_i),
    .tag_o    (b_tag),
    .sealed_o (b_sealed),
    .perms_o  (b_perms),
    .otype_o  (),
    .base_o   (b_base),
    .addr_o   (b_addr),
    .offset_o (),
    .top_o    (b_top)
  );

  cap_check_stage u_check (
    .clk_i                   (clk_i),
    .rst_n_i                 (rst_n_i),
    .in_valid_i              (in_valid_i),
    .op_i                    (op_i),
    .operand_a_i             (operand_a_i),
    .operand_b_i             (operand_b_i),
    .a_tag_i                 (a_tag),
    .a_sealed_i              (a_sealed),
    .a_perms_i               (a_perms),
    .a_otype_i               (a_otype),
    .a_base_i                (a_base),
    .a_top_i                 (a_top),
    .a_addr_i                (a_addr),
    .a_offset_i              (a_offset),
    .b_tag_i                 (b_tag),
    .b_sealed_i              (b_sealed),
    .b_perms_i               (b_perms),
    .b_base_i                (b_base),
    .b_top_i                 (b_top),
    .b_addr_i                (b_addr),
    .valid_o                 (chk_valid),
    .op_o                    (chk_op),
    .operand_a_o             (chk_operand_a),
    .operand_b_o             (chk_operand_b),
    .a_offset_o              (chk_a_offset),
    .a_tag_bad_o             (a_tag_bad),
    .a_seal_bad_o            (a_seal_bad),
    .a_sealed_o              (chk_a_sealed),
    .b_tag_bad_o             (b_tag_bad),
    .b_seal_bad_o            (b_seal_bad),
    .b_sealed_o              (chk_b_sealed),
    .b_no_seal_perm_o        (b_no_seal_perm),
    .b_no_unseal_perm_o      (b_no_unseal_perm),
    .b_addr_out_of_bounds_o  (b_addr_out_of_bounds),
    .b_addr_over_max_otype_o (b_addr_over_max_otype),
    .a_bounds_bad_o          (a_bounds_bad),
    .type_mismatch_o         (type_mismatch),
    .subset_o                (subset)
  );

  cap_execute u_execute (
    .clk_i                   (clk_i),
    .rst_n_i                 (rst_n_i),
    .valid_i                 (chk_valid),
    .op_i                    (chk_op),
    .operand_a_i             (chk_operand_a),
    .operand_b_i             (chk_operand_b),
    .a_offset_i              (chk_a_offset),
    .a_tag_bad_i             (a_tag_bad),
    .a_seal_bad_i            (a_seal_bad),
    .a_sealed_i              (chk_a_sealed),
    .b_tag_bad_i             (b_tag_bad),
    .b_seal_bad_i            (b_seal_bad),
    .b_sealed_i              (chk_b_sealed),
    .b_no_seal_perm_i        (b_no_seal_perm),
    .b_no_unseal_perm_i      (b_no_unseal_perm),
    .b_addr_out_of_bounds_i  (b_addr_out_of_bounds),
    .b_addr_over_max_otype_i (b_addr_over_max_otype),
    .a_bounds_bad_i          (a_bounds_bad),
    .type_mismatch_i         (type_mismatch),
    .subset_i                (subset),
    .valid_o                 (out_valid_o),
    .result_o                (result_o),
    .wrote_cap_o             (wrote_cap_o),
    .exc_a_o                 (exc_a_o),
    .exc_b_o                 (exc_b_o)
  );

endmodule

// File: rtl/cheri_cap_pkg.sv
`include "cheri_cap_settings.svh"

package cheri_cap_pkg;

  // capability view of an operand word, listed from the most significant bit down
  // the layout is uncompressed, so base and length are always exact
  typedef struct packed {
    logic                tag;
    logic [`PERMS_W-1:0] perms;
    logic [`OTYPE_W-1:0] otype;
    logic [`INT_W-1:0]   base;
    logic [`INT_W-1:0]   length;
    logic [`INT_W-1:0]   addr;
  } cap_fields_s;

  // integer view of the same word
  // the value sits in the low bits, on top of the addr field of the capability view
  typedef struct packed {
    logic [`CAP_W-`INT_W-1:0] upper;
    logic [`INT_W-1:0]        value;
  } cap_int_s;

  // one register word, read as a capability or as a plain integer depending on the op
  // integer results are written with the upper field cleared
  typedef union packed {
    cap_fields_s cap;
    cap_int_s    num;
  } cap_word_u;

endpackage

// File: rtl/cheri_cap_settings.svh
`ifndef CHERI_CAP_SETTINGS_SVH
`define CHERI_CAP_SETTINGS_SVH

// widths of the uncompressed capability and its fields
`define CAP_W 113
`define INT_W 32
`define PERMS_W 12
`define OTYPE_W 4
`define TOP_W 33

// an all-ones object type marks an unsealed capability
`define OTYPE_UNSEALED {`OTYPE_W{1'b1}}
`define MAX_OTYPE 32'hc

// permission bit positions inside the perms field
`define PERMIT_GLOBAL_IDX 0
`define PERMIT_SEAL_IDX 7
`define PERMIT_UNSEAL_IDX 9

// bit positions inside each exception vector
`define EXC_W 6
`define EXC_TAG 0
`define EXC_SEAL 1
`define EXC_LENGTH 2
`define EXC_TYPE 3
`define EXC_PERMIT_SEAL 4
`define EXC_PERMIT_UNSEAL 5

// operation codes
`define OP_W 5
`define OP_GET_PERM 5'd0
`define OP_GET_TYPE 5'd1
`define OP_GET_BASE 5'd2
`define OP_GET_LEN 5'd3
`define OP_GET_TAG 5'd4
`define OP_GET_SEALED 5'd5
`define OP_GET_OFFSET 5'd6
`define OP_GET_ADDR 5'd7
`define OP_MOVE 5'd8
`define OP_CLEAR_TAG 5'd9
`define OP_AND_PERM 5'd10
`define OP_SET_ADDR 5'd11
`define OP_INC_OFFSET 5'd12
`define OP_SET_BOUNDS 5'd13
`define OP_SEAL 5'd14
`define OP_UNSEAL 5'd15
`define OP_SUB 5'd16
`define OP_TEST_SUBSET 5'd17

`endif

// File: test/cap_alu_cases.txt
# op a b result wrote_cap exc_a exc_b, all hex, one case per line
# capability words are tag perms otype base length addr from the top down
00 1ffff000010000000100000001800 0 fff 0 00 00
00 10a5f000001000000001000000080 0 a5 0 00 00
01 1ffff000010000000100000001800 0 ffffffff 0 00 00
01 1fff3000010000000100000001800 0 3 0 00 00
02 1ffff000010000000100000001800 0 1000 0 00 00
03 10a5f000001000000001000000080 0 10 0 00 00
04 1ffff000010000000100000001800 0 1 0 00 00
04 0ffff000010000000100000001800 0 0 0 00 00
05 1fff3000010000000100000001800 0 1 0 00 00
05 1ffff000010000000100000001800 0 0 0 00 00
06 1ffff000010000000100000001800 0 800 0 00 00
06 10a5f000001000000001000000080 0 ffffff80 0 00 00
07 1ffff000010000000100000001800 0 1800 0 00 00
08 1fff3000010000000100000001800 0 1fff3000010000000100000001800 1 00 00
09 1ffff000010000000100000001800 0 0ffff000010000000100000001800 1 00 00
0a 1ffff000010000000100000001800 f0f 1f0ff000010000000100000001800 1 00 00
0a 0ffff000010000000100000001800 3 0003f000010000000100000001800 1 01 00
0a 1fff3000010000000100000001800 fff 1fff3000010000000100000001800 1 02 00
0b 1ffff000010000000100000001800 1234 1ffff000010000000100000001234 1 00 00
0b 1fff3000010000000100000001800 1900 1fff3000010000000100000001900 1 02 00
0c 1ffff000010000000100000001800 100 1ffff000010000000100000001900 1 00 00
0c 1ffff000010000000100000001800 ffffffff 1ffff0000100000001000000017ff 1 00 00
0d 1ffff000010000000100000001800 400 1ffff000018000000040000001800 1 00 00
0d 1ffff000010000000100000001800 900 1ffff000018000000090000001800 1 04 00
0d 10a5f000001000000001000000080 10 10a5f000000800000001000000080 1 04 00
0e 1ffff000010000000100000001800 1ffff000000000000001000000005 1fff5000010000000100000001800 1 00 00
0e 1ffff000010000000100000001800 1f7ff000000000000001000000005 1fff5000010000000100000001800 1 00 10
0e 1ffff000010000000100000001800 1ffff000000000000000400000005 1fff5000010000000100000001800 1 00 04
0e 1ffff000010000000100000001800 1ffff00000000000000100000000d 1fffd000010000000100000001800 1 00 04
0e 0ffff000010000000100000001800 1ffff000000000000001000000005 0fff5000010000000100000001800 1 01 00
0f 1fff5000010000000100000001800 1ffff000000000000001000000005 1ffff000010000000100000001800 1 00 00
0f 1fff5000010000000100000001800 1ffef000000000000001000000005 1ffef000010000000100000001800 1 00 00
0f 1fff3000010000000100000001800 1ffff000000000000001000000005 1ffff000010000000100000001800 1 00 08
0f 1ffff000010000000100000001800 1ffff000000000000001000000005 1ffff000010000000100000001800 1 02 08
10 1ffff000010000000100000001800 1ffff000000000000001000000005 17fb 0 00 00
10 1ffff000000000000001000000005 1ffff000010000000100000001800 ffffe805 0 00 00
11 1ffff000010000000100000001800 10f0f000012000000010000001200 1 0 00 00
11 1ffff000010000000100000001800 10f0f00000f000000010000000f00 0 0 00 00
11 1f0ff000010000000100000001800 10f0f000012000000010000001200 0 0 00 00
11 1ffff000010000000100000001800 00f0f000012000000010000001200 0 0 00 00
11 0ffff000010000000100000001800 00f0f000012000000010000001200 1 0 00 00

// File: test/tb_cheri_cap_alu.sv
`include "cheri_cap_settings.svh"
`timescale 1ns/1ps

// self-checking testbench for the capability ALU
// every case from the case file is issued as a one-cycle strobe and its expected
// response is matched against the out_valid_o pulse that must follow two cycles later
module tb_cheri_cap_alu;
  import cheri_cap_pkg::*;

  localparam int CLK_PERIOD   = 8;
  localparam int RESET_CYCLES = 16;
  localparam int LATENCY      = 2;

  logic              clk;
  logic              rst_n;
  logic              in_valid;
  logic [`OP_W-1:0]  op;
  cap_word_u         operand_a;
  cap_word_u         operand_b;
  logic              out_valid;
  cap_word_u         result;
  logic              wrote_cap;
  logic [`EXC_W-1:0] exc_a;
  logic [`EXC_W-1:0] exc_b;

  // cases in file order
  logic [`OP_W-1:0]  case_op_q[$];
  logic [`CAP_W-1:0] case_a_q[$];
  logic [`CAP_W-1:0] case_b_q[$];
  logic [`CAP_W-1:0] case_result_q[$];
  logic              case_wrote_q[$];
  logic [`EXC_W-1:0] case_exc_a_q[$];
  logic [`EXC_W-1:0] case_exc_b_q[$];

  // responses the DUT still owes, oldest at the front
  int                pend_index_q[$];
  int                pend_due_q[$];
  logic [`CAP_W-1:0] pend_result_q[$];
  logic              pend_wrote_q[$];
  logic [`EXC_W-1:0] pend_exc_a_q[$];
  logic [`EXC_W-1:0] pend_exc_b_q[$];

  int     num_cases      = 0;
  bit     cases_loaded   = 1'b0;
  int     cycle_count    = 0;
  int     responses_seen = 0;
  int     value_errors   = 0;
  int     other_errors   = 0;
  integer seed;

  always #(CLK_PERIOD / 2) clk = ~clk;

  // rising edges since time zero, the reference for the latency check
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
  end

  cheri_cap_alu u_cheri_cap_alu (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .in_valid_i  (in_valid),
    .op_i        (op),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .out_valid_o (out_valid),
    .result_o    (result),
    .wrote_cap_o (wrote_cap),
    .exc_a_o     (exc_a),
    .exc_b_o     (exc_b)
  );

  // lines starting with # are column notes and are skipped
  task automatic load_cases();
    integer            fd;
    integer            n;
    string             line;
    logic [`OP_W-1:0]  f_op;
    logic [`CAP_W-1:0] f_a;
    logic [`CAP_W-1:0] f_b;
    logic [`CAP_W-1:0] f_res;
    logic              f_wrote;
    logic [`EXC_W-1:0] f_exc_a;
    logic [`EXC_W-1:0] f_exc_b;
    fd = $fopen("test/cap_alu_cases.txt", "r");
    assert (fd != 0) else begin
      other_errors++;
      $display("the case file test/cap_alu_cases.txt could not be opened");
    end
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        if (n > 0 && line.len() > 1 && line.substr(0, 0) != "#") begin
          n = $sscanf(line, "%h %h %h %h %h %h %h",
                      f_op, f_a, f_b, f_res, f_wrote, f_exc_a, f_exc_b);
          assert (n == 7) else begin
            other_errors++;
            $display("a line of the case file could not be read: %s", line);
          end
          if (n == 7) begin
            case_op_q.push_back(f_op);
            case_a_q.push_back(f_a);
            case_b_q.push_back(f_b);
            case_result_q.push_back(f_res);
            case_wrote_q.push_back(f_wrote);
            case_exc_a_q.push_back(f_exc_a);
            case_exc_b_q.push_back(f_exc_b);
          end
        end
      end
      $fclose(fd);
      num_cases = case_op_q.size();
      assert (num_cases > 0) else begin
        other_errors++;
        $display("the case file holds no cases");
      end
    end
    cases_loaded = 1'b1;
  endtask

  task automatic idle_cycle();
    @(negedge clk);
    in_valid = 1'b0;
  endtask

  // the expected entry is queued with the cycle on which its result is due
  task automatic issue_case(input int idx);
    @(negedge clk);
    in_valid  = 1'b1;
    op        = case_op_q[idx];
    operand_a = case_a_q[idx];
    operand_b = case_b_q[idx];
    pend_index_q.push_back(idx);
    pend_due_q.push_back(cycle_count + LATENCY);
    pend_result_q.push_back(case_result_q[idx]);
    pend_wrote_q.push_back(case_wrote_q[idx]);
    pend_exc_a_q.push_back(case_exc_a_q[idx]);
    pend_exc_b_q.push_back(case_exc_b_q[idx]);
  endtask

  task automatic drop_pending();
    void'(pend_index_q.pop_front());
    void'(pend_due_q.pop_front());
    void'(pend_result_q.pop_front());
    void'(pend_wrote_q.pop_front());
    void'(pend_exc_a_q.pop_front());
    void'(pend_exc_b_q.pop_front());
  endtask

  task automatic check_value(input int idx, input string name,
                             input logic [`CAP_W-1:0] expected,
                             input logic [`CAP_W-1:0] actual);
    assert (actual === expected) else begin
      value_errors++;
      $display("ERR %0t case %0d %s expected %0h actual %0h",
               $time, idx, name, expected, actual);
    end
  endtask

  // compares one out_valid_o pulse with the oldest owed response
  task automatic take_response();
    int idx;
    assert (pend_due_q.size() != 0) else begin
      other_errors++;
      $display("out_valid_o was raised at %0t with no operation in flight", $time);
    end
    if (pend_due_q.size() != 0) begin
      idx = pend_index_q[0];
      check_value(idx, "out_valid_o cycle", pend_due_q[0], cycle_count);
      check_value(idx, "result_o", pend_result_q[0], result);
      check_value(idx, "wrote_cap_o", pend_wrote_q[0], wrote_cap);
      check_value(idx, "exc_a_o", pend_exc_a_q[0], exc_a);
      check_value(idx, "exc_b_o", pend_exc_b_q[0], exc_b);
      drop_pending();
      responses_seen++;
    end
  endtask

  // outputs move on the rising edge, so they are sampled on the falling one
  always @(negedge clk) begin
    if (!rst_n) begin
      if (cycle_count > 0) begin
        check_value(-1, "out_valid_o in reset", '0, out_valid);
      end
    end else if (out_valid === 1'b1) begin
      take_response();
    end else begin
      assert (out_valid === 1'b0) else begin
        other_errors++;
        $display("out_valid_o is unknown at %0t", $time);
      end
      assert (pend_due_q.size() == 0 || pend_due_q[0] > cycle_count) else begin
        other_errors++;
        $display("case %0d got no out_valid_o %0d cycles after its issue, time %0t",
                 pend_index_q[0], LATENCY, $time);
        drop_pending();
      end
    end
  end

  initial begin
    int idle;
    int i;
    seed      = 32'hc1315bba;
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    op        = '0;
    operand_a = '0;
    operand_b = '0;
    load_cases();

    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    repeat (2) idle_cycle();

    // the first two of every four cases go back to back, so two ops share the pipeline
    for (i = 0; i < num_cases; i++) begin
      if (i % 4 < 2) begin
        idle = 0;
      end else begin
        idle = $unsigned($random(seed)) % 3;
      end
      repeat (idle) idle_cycle();
      issue_case(i);
    end
    idle_cycle();

    // drain, then watch a few more cycles for a stray out_valid_o
    while (pend_due_q.size() != 0) @(negedge clk);
    repeat (4) @(negedge clk);

    assert (responses_seen == num_cases) else begin
      other_errors++;
      $display("%0d responses arrived for %0d cases", responses_seen, num_cases);
    end

    $display("errors: %0d value mismatches, %0d other failures", value_errors, other_errors);
    if (value_errors == 0 && other_errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

  // the limit grows with the case count, each case takes at most about three cycles
  initial begin
    wait (cases_loaded);
    #((RESET_CYCLES + 4 * num_cases + 20) * CLK_PERIOD);
    $display("timeout: %0d responses were still owed when the time limit ran out",
             pend_due_q.size());
    $display("errors: %0d value mismatches, %0d other failures",
             value_errors, other_errors + 1);
    $display("SIMULATION FAILED");
    $finish;
  end

endmodule
